//--- src.f
tlb_pkg.sv
tlb_entry_table.sv
tlb_lookup.sv
tlb_arbiter.sv
tlb_top.sv
tlb_checker.sv
tlb_tb.sv

//--- tlb_tb.sv
// Self-checking run of five directed and random tests; stimulus from a fixed-seed LFSR
module tlb_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 5;

  typedef struct packed {
    logic        hit;
    logic [35:0] addr;
    logic [3:0]  id;
    logic [7:0]  len;
    logic [1:0]  burst;
  } exp_t;

  logic clk_i;
  logic rst_n_i;
  logic aw_valid_i, aw_ready_o, ar_valid_i, ar_ready_o;
  logic [31:0] aw_addr_i, ar_addr_i;
  logic [3:0] aw_id_i, ar_id_i, mst_id_o, err_id_o;
  logic [7:0] aw_len_i, ar_len_i, mst_len_o;
  logic [1:0] ar_burst_i, mst_burst_o;
  logic cfg_we_i;
  logic [1:0] cfg_idx_i;
  tlb_pkg::tlb_entry_t cfg_entry_i;
  logic mst_valid_o, mst_ready_i, mst_we_o, err_valid_o, err_ready_i, err_we_o;
  logic [35:0] mst_addr_o;

  tlb_pkg::tlb_entry_t ref_tab [4];
  exp_t  wr_q [$];
  exp_t  rd_q [$];
  logic [31:0] lfsr = 32'h4920_f12f;
  logic  stall_en;
  string test_name;

  tlb_top uut (.*);

  bind tlb_top tlb_checker i_checker (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .aw_valid_i (aw_valid_i), .aw_ready_i (aw_ready_o),
    .ar_valid_i (ar_valid_i), .ar_ready_i (ar_ready_o),
    .mst_valid_i (mst_valid_o), .mst_ready_i (mst_ready_i), .mst_we_i (mst_we_o),
    .mst_addr_i (mst_addr_o), .mst_id_i (mst_id_o), .mst_len_i (mst_len_o),
    .mst_burst_i (mst_burst_o), .err_valid_i (err_valid_o), .err_ready_i (err_ready_i),
    .err_we_i (err_we_o), .err_id_i (err_id_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2, 1; one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // Half the addresses land near the start of a configured range
  function automatic logic [31:0] pick_addr();
    logic [31:0] a;
    logic [1:0]  k;
    a = rand_bits(32);
    k = 2'(rand_bits(2));
    if (rand_bits(1) == 32'd1) begin
      a[31:12] = ref_tab[k].first_page + 20'(rand_bits(5));
    end
    return a;
  endfunction

  // Reference translation: first valid range hit in index order, writes skip read-only
  function automatic exp_t expected_result(input logic is_wr, input logic [31:0] addr,
                                           input logic [3:0] id, input logic [7:0] len,
                                           input logic [1:0] burst);
    exp_t        e;
    logic [19:0] page;
    e       = '0;
    e.id    = id;
    e.len   = len;
    e.burst = is_wr ? tlb_pkg::BURST_INCR : burst;
    page    = addr[31:12];
    for (int i = 0; i < 4; i++) begin
      if (!e.hit && ref_tab[i].valid && page >= ref_tab[i].first_page
          && page <= ref_tab[i].last_page && !(is_wr && ref_tab[i].read_only)) begin
        e.hit  = 1'b1;
        e.addr = {ref_tab[i].out_base + 24'(page - ref_tab[i].first_page), addr[11:0]};
      end
    end
    return e;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_field(input string field, input logic [35:0] exp_v,
                             input logic [35:0] act_v);
    assert (exp_v === act_v) else begin
      stop_run($sformatf("ERR %s %s: expected %h actual %h", test_name, field, exp_v, act_v));
    end
  endtask

  task automatic match_output(input logic hit, input logic we, input logic [35:0] addr,
                              input logic [3:0] id, input logic [7:0] len,
                              input logic [1:0] burst);
    exp_t  e;
    string dir;
    dir = we ? "write" : "read";
    if ((we && wr_q.size() == 0) || (!we && rd_q.size() == 0)) begin
      stop_run($sformatf("A %s came out in %s that was never requested", dir, test_name));
    end else begin
      if (we) e = wr_q.pop_front();
      else e = rd_q.pop_front();
      check_field({dir, " hit"}, 36'(e.hit), 36'(hit));
      check_field({dir, " id"}, 36'(e.id), 36'(id));
      if (hit) begin
        check_field({dir, " addr"}, e.addr, addr);
        check_field({dir, " len"}, 36'(e.len), 36'(len));
        check_field({dir, " burst"}, 36'(e.burst), 36'(burst));
      end
    end
  endtask

  // Outputs first, then new acceptances, then the table as it was at this edge
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 4; i++) ref_tab[i] <= '0;
    end else begin
      if (mst_valid_o && mst_ready_i)
        match_output(1'b1, mst_we_o, mst_addr_o, mst_id_o, mst_len_o, mst_burst_o);
      if (err_valid_o && err_ready_i)
        match_output(1'b0, err_we_o, '0, err_id_o, '0, '0);
      if (aw_valid_i && aw_ready_o)
        wr_q.push_back(expected_result(1'b1, aw_addr_i, aw_id_i, aw_len_i, 2'b00));
      if (ar_valid_i && ar_ready_o)
        rd_q.push_back(expected_result(1'b0, ar_addr_i, ar_id_i, ar_len_i, ar_burst_i));
      if (cfg_we_i) ref_tab[cfg_idx_i] <= cfg_entry_i;
    end
  end

  always @(posedge clk_i) begin
    mst_ready_i <= stall_en ? (rand_bits(2) != 32'd0) : 1'b1;
    err_ready_i <= stall_en ? (rand_bits(2) != 32'd0) : 1'b1;
  end

  task automatic send_write(input logic [31:0] addr, input logic [3:0] id,
                            input logic [7:0] len);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    aw_id_i    <= id;
    aw_len_i   <= len;
    do @(posedge clk_i); while (!aw_ready_o);
    aw_valid_i <= 1'b0;
  endtask

  task automatic send_read(input logic [31:0] addr, input logic [3:0] id,
                           input logic [7:0] len, input logic [1:0] burst);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    ar_id_i    <= id;
    ar_len_i   <= len;
    ar_burst_i <= burst;
    do @(posedge clk_i); while (!ar_ready_o);
    ar_valid_i <= 1'b0;
  endtask

  task automatic write_entry(input logic [1:0] idx, input logic ro, input logic [19:0] first,
                             input logic [19:0] last, input logic [23:0] base);
    cfg_we_i    <= 1'b1;
    cfg_idx_i   <= idx;
    cfg_entry_i <= '{valid: 1'b1, read_only: ro, first_page: first, last_page: last,
                     out_base: base};
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  task automatic random_traffic(input int n);
    fork
      for (int i = 0; i < n; i++) send_write(pick_addr(), 4'(rand_bits(4)), 8'(rand_bits(8)));
      for (int j = 0; j < n; j++)
        send_read(pick_addr(), 4'(rand_bits(4)), 8'(rand_bits(8)), 2'(rand_bits(2)));
    join
  endtask

  // Every expected record consumed, then a few idle cycles to catch extra outputs
  task automatic wait_drain();
    while (wr_q.size() != 0 || rd_q.size() != 0) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
  endtask

  initial begin
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    stop_run($sformatf("Watchdog timeout: %s did not finish in time", test_name));
  end

  // Bound protocol assertions count their failures in the checker
  always @(posedge clk_i) begin
    if (uut.i_checker.fail_cnt != 0) begin
      stop_run("A protocol assertion in the bound checker failed");
    end
  end

  initial begin
    rst_n_i = 1'b0;
    {aw_valid_i, aw_addr_i, aw_id_i, aw_len_i} = '0;
    {ar_valid_i, ar_addr_i, ar_id_i, ar_len_i, ar_burst_i} = '0;
    {cfg_we_i, cfg_idx_i, cfg_entry_i} = '0;
    {mst_ready_i, err_ready_i, stall_en} = '0;
    test_name = "reset_state";
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      send_write(rand_bits(32), 4'(rand_bits(4)), 8'(rand_bits(8)));
      send_read(rand_bits(32), 4'(rand_bits(4)), 8'(rand_bits(8)), 2'(rand_bits(2)));
    end
    wait_drain();

    test_name = "range_translation";
    write_entry(2'd0, 1'b0, 20'h00100, 20'h0010F, 24'h000A00);
    write_entry(2'd1, 1'b0, 20'h20000, 20'h2000F, 24'hF00000);
    write_entry(2'd2, 1'b0, 20'h80000, 20'h8000F, 24'h123456);
    write_entry(2'd3, 1'b0, 20'hFFFF0, 20'hFFFFF, 24'hABCDE0);
    random_traffic(12);
    wait_drain();

    test_name = "overlap_permission";
    write_entry(2'd1, 1'b0, 20'h00108, 20'h0011F, 24'h555000);
    write_entry(2'd2, 1'b1, 20'h80000, 20'h8000F, 24'h123456);
    send_write(32'h0010_A123, 4'h1, 8'h00);
    send_read(32'h0011_C456, 4'h2, 8'h0F, 2'b01);
    send_write(32'h8000_5ABC, 4'h3, 8'h07);
    send_read(32'h8000_5ABC, 4'h4, 8'h07, 2'b10);
    wait_drain();

    // The read accepted on the strobe edge still sees the old mapping
    test_name = "reconfiguration";
    fork
      write_entry(2'd3, 1'b0, 20'hFFFF0, 20'hFFFFF, 24'h00C000);
      send_read(32'hFFFF_4321, 4'h7, 8'h03, 2'b01);
    join
    send_read(32'hFFFF_4321, 4'h8, 8'h03, 2'b01);
    send_write(32'hFFFF_8765, 4'h9, 8'h01);
    wait_drain();

    test_name = "concurrency_backpressure";
    stall_en = 1'b1;
    random_traffic(40);
    wait_drain();
    stall_en = 1'b0;

    if (uut.i_checker.fail_cnt != 0) begin
      stop_run("Protocol assertions in the bound checker failed");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

//--- tlb_checker.sv
// Bound into tlb_top; covers port protocol only, translated values are checked by the testbench
module tlb_checker (
  input logic                            clk_i,
  input logic                            rst_n_i,
  input logic                            aw_valid_i,
  input logic                            aw_ready_i,
  input logic                            ar_valid_i,
  input logic                            ar_ready_i,
  input logic                            mst_valid_i,
  input logic                            mst_ready_i,
  input logic                            mst_we_i,
  input logic [tlb_pkg::OUT_ADDR_W-1:0]  mst_addr_i,
  input logic [tlb_pkg::ID_W-1:0]        mst_id_i,
  input logic [tlb_pkg::LEN_W-1:0]       mst_len_i,
  input logic [tlb_pkg::BURST_W-1:0]     mst_burst_i,
  input logic                            err_valid_i,
  input logic                            err_ready_i,
  input logic                            err_we_i,
  input logic [tlb_pkg::ID_W-1:0]        err_id_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // Master request held with stable fields while stalled
  mst_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_valid_i && !mst_ready_i |=> mst_valid_i
      && $stable({mst_we_i, mst_addr_i, mst_id_i, mst_len_i, mst_burst_i}))
  else begin
    $error("master request changed while stalled");
    fail_cnt++;
  end

  err_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    err_valid_i && !err_ready_i |=> err_valid_i && $stable({err_we_i, err_id_i}))
  else begin
    $error("error response changed while stalled");
    fail_cnt++;
  end

  // Covers every reset cycle and the first cycle after release
  quiet_reset: assert property (@(posedge clk_i) !rst_n_i |=> !mst_valid_i && !err_valid_i)
  else begin
    $error("output valid during or right after reset");
    fail_cnt++;
  end

  one_port: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(mst_valid_i && err_valid_i))
  else begin
    $error("master and error ports valid together");
    fail_cnt++;
  end

  wr_answer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    aw_valid_i && aw_ready_i |-> ##[1:64]
      ((mst_valid_i && mst_ready_i && mst_we_i) || (err_valid_i && err_ready_i && err_we_i)))
  else begin
    $error("write request not answered within 64 cycles");
    fail_cnt++;
  end

  rd_answer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ar_valid_i && ar_ready_i |-> ##[1:64]
      ((mst_valid_i && mst_ready_i && !mst_we_i) || (err_valid_i && err_ready_i && !err_we_i)))
  else begin
    $error("read request not answered within 64 cycles");
    fail_cnt++;
  end

endmodule

//--- tlb_top.sv
// Two address channels share one four-entry table; uncontested requests leave one cycle later
module tlb_top (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Write-address channel
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  logic [tlb_pkg::IN_ADDR_W-1:0]   aw_addr_i,
  input  logic [tlb_pkg::ID_W-1:0]        aw_id_i,
  input  logic [tlb_pkg::LEN_W-1:0]       aw_len_i,
  // Read-address channel
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  logic [tlb_pkg::IN_ADDR_W-1:0]   ar_addr_i,
  input  logic [tlb_pkg::ID_W-1:0]        ar_id_i,
  input  logic [tlb_pkg::LEN_W-1:0]       ar_len_i,
  input  logic [tlb_pkg::BURST_W-1:0]     ar_burst_i,
  // Table configuration
  input  logic                            cfg_we_i,
  input  logic [tlb_pkg::ENTRY_IDX_W-1:0] cfg_idx_i,
  input  tlb_pkg::tlb_entry_t             cfg_entry_i,
  // Master request port
  output logic                            mst_valid_o,
  input  logic                            mst_ready_i,
  output logic                            mst_we_o,
  output logic [tlb_pkg::OUT_ADDR_W-1:0]  mst_addr_o,
  output logic [tlb_pkg::ID_W-1:0]        mst_id_o,
  output logic [tlb_pkg::LEN_W-1:0]       mst_len_o,
  output logic [tlb_pkg::BURST_W-1:0]     mst_burst_o,
  // Error port
  output logic                            err_valid_o,
  input  logic                            err_ready_i,
  output logic                            err_we_o,
  output logic [tlb_pkg::ID_W-1:0]        err_id_o
);

  tlb_pkg::tlb_entry_t [tlb_pkg::NUM_ENTRIES-1:0] entries;

  tlb_pkg::wr_meta_t               aw_meta;
  tlb_pkg::rd_meta_t               ar_meta;

  // Lookup results towards the arbiter
  logic                            wr_res_valid;
  logic                            wr_res_ready;
  logic                            wr_res_hit;
  logic [tlb_pkg::OUT_ADDR_W-1:0]  wr_res_addr;
  tlb_pkg::wr_meta_t               wr_res_meta;
  logic                            rd_res_valid;
  logic                            rd_res_ready;
  logic                            rd_res_hit;
  logic [tlb_pkg::OUT_ADDR_W-1:0]  rd_res_addr;
  tlb_pkg::rd_meta_t               rd_res_meta;

  assign aw_meta = '{id: aw_id_i, len: aw_len_i};
  assign ar_meta = '{id: ar_id_i, len: ar_len_i, burst: ar_burst_i};

  tlb_entry_table i_table (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_idx_i   ( cfg_idx_i   ),
    .cfg_entry_i ( cfg_entry_i ),
    .entries_o   ( entries     )
  );

  tlb_lookup #(
    .payload_t ( tlb_pkg::wr_meta_t )
  ) i_wr_lookup (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .req_valid_i   ( aw_valid_i   ),
    .req_ready_o   ( aw_ready_o   ),
    .req_addr_i    ( aw_addr_i    ),
    .req_payload_i ( aw_meta      ),
    .is_write_i    ( 1'b1         ),
    .entries_i     ( entries      ),
    .res_valid_o   ( wr_res_valid ),
    .res_ready_i   ( wr_res_ready ),
    .res_hit_o     ( wr_res_hit   ),
    .res_addr_o    ( wr_res_addr  ),
    .res_payload_o ( wr_res_meta  )
  );

  tlb_lookup #(
    .payload_t ( tlb_pkg::rd_meta_t )
  ) i_rd_lookup (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .req_valid_i   ( ar_valid_i   ),
    .req_ready_o   ( ar_ready_o   ),
    .req_addr_i    ( ar_addr_i    ),
    .req_payload_i ( ar_meta      ),
    .is_write_i    ( 1'b0         ),
    .entries_i     ( entries      ),
    .res_valid_o   ( rd_res_valid ),
    .res_ready_i   ( rd_res_ready ),
    .res_hit_o     ( rd_res_hit   ),
    .res_addr_o    ( rd_res_addr  ),
    .res_payload_o ( rd_res_meta  )
  );

  tlb_arbiter i_arbiter (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .wr_valid_i  ( wr_res_valid ),
    .wr_ready_o  ( wr_res_ready ),
    .wr_hit_i    ( wr_res_hit   ),
    .wr_addr_i   ( wr_res_addr  ),
    .wr_meta_i   ( wr_res_meta  ),
    .rd_valid_i  ( rd_res_valid ),
    .rd_ready_o  ( rd_res_ready ),
    .rd_hit_i    ( rd_res_hit   ),
    .rd_addr_i   ( rd_res_addr  ),
    .rd_meta_i   ( rd_res_meta  ),
    .mst_valid_o ( mst_valid_o  ),
    .mst_ready_i ( mst_ready_i  ),
    .mst_we_o    ( mst_we_o     ),
    .mst_addr_o  ( mst_addr_o   ),
    .mst_id_o    ( mst_id_o     ),
    .mst_len_o   ( mst_len_o    ),
    .mst_burst_o ( mst_burst_o  ),
    .err_valid_o ( err_valid_o  ),
    .err_ready_i ( err_ready_i  ),
    .err_we_o    ( err_we_o     ),
    .err_id_o    ( err_id_o     )
  );

endmodule

//--- tlb_arbiter.sv
// Grants one result per cycle with alternating priority; a stalled grant is held until taken
module tlb_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  // Write lookup result
  input  logic                            wr_valid_i,
  output logic                            wr_ready_o,
  input  logic                            wr_hit_i,
  input  logic [tlb_pkg::OUT_ADDR_W-1:0]  wr_addr_i,
  input  tlb_pkg::wr_meta_t               wr_meta_i,
  // Read lookup result
  input  logic                            rd_valid_i,
  output logic                            rd_ready_o,
  input  logic                            rd_hit_i,
  input  logic [tlb_pkg::OUT_ADDR_W-1:0]  rd_addr_i,
  input  tlb_pkg::rd_meta_t               rd_meta_i,
  // Master request port for hits
  output logic                            mst_valid_o,
  input  logic                            mst_ready_i,
  output logic                            mst_we_o,
  output logic [tlb_pkg::OUT_ADDR_W-1:0]  mst_addr_o,
  output logic [tlb_pkg::ID_W-1:0]        mst_id_o,
  output logic [tlb_pkg::LEN_W-1:0]       mst_len_o,
  output logic [tlb_pkg::BURST_W-1:0]     mst_burst_o,
  // Error port for misses
  output logic                            err_valid_o,
  input  logic                            err_ready_i,
  output logic                            err_we_o,
  output logic [tlb_pkg::ID_W-1:0]        err_id_o
);

  // Read channel wins the next tie when set
  logic                      prio_rd_q;
  logic                      wr_sel;
  logic                      rd_sel;
  logic                      any_sel;
  logic                      sel_hit;
  logic                      port_ready;
  logic                      grant;
  logic [tlb_pkg::ID_W-1:0]  sel_id;

  assign wr_sel  = wr_valid_i && (!rd_valid_i || !prio_rd_q);
  assign rd_sel  = rd_valid_i && !wr_sel;
  assign any_sel = wr_sel || rd_sel;
  assign sel_hit = wr_sel ? wr_hit_i : rd_hit_i;
  assign sel_id  = wr_sel ? wr_meta_i.id : rd_meta_i.id;

  // Only the port the winner is routed to can complete the grant
  assign port_ready = sel_hit ? mst_ready_i : err_ready_i;
  assign grant      = any_sel && port_ready;
  assign wr_ready_o = wr_sel && port_ready;
  assign rd_ready_o = rd_sel && port_ready;

  assign mst_valid_o = any_sel && sel_hit;
  assign mst_we_o    = wr_sel;
  assign mst_addr_o  = wr_sel ? wr_addr_i : rd_addr_i;
  assign mst_id_o    = sel_id;
  assign mst_len_o   = wr_sel ? wr_meta_i.len : rd_meta_i.len;
  assign mst_burst_o = wr_sel ? tlb_pkg::BURST_INCR : rd_meta_i.burst;

  assign err_valid_o = any_sel && !sel_hit;
  assign err_we_o    = wr_sel;
  assign err_id_o    = sel_id;

  // After a grant the other channel is favoured; while a presented result
  // waits, the bit keeps pointing at it so the output stays stable
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      prio_rd_q <= 1'b0;
    end else if (grant) begin
      prio_rd_q <= wr_sel;
    end else if (any_sel) begin
      prio_rd_q <= rd_sel;
    end
  end

endmodule

//--- tlb_lookup.sv
// One result register per channel; lowest matching entry wins and a miss yields address zero
module tlb_lookup #(
  parameter type payload_t = logic
) (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // Request side
  input  logic                                            req_valid_i,
  output logic                                            req_ready_o,
  input  logic [tlb_pkg::IN_ADDR_W-1:0]                   req_addr_i,
  input  payload_t                                        req_payload_i,
  // Constant per instance, high on the write channel
  input  logic                                            is_write_i,
  input  tlb_pkg::tlb_entry_t [tlb_pkg::NUM_ENTRIES-1:0]  entries_i,
  // Result side
  output logic                                            res_valid_o,
  input  logic                                            res_ready_i,
  output logic                                            res_hit_o,
  output logic [tlb_pkg::OUT_ADDR_W-1:0]                  res_addr_o,
  output payload_t                                        res_payload_o
);

  logic [tlb_pkg::IN_PAGE_W-1:0]   in_page;
  logic [tlb_pkg::PAGE_OFS_W-1:0]  in_ofs;
  logic [tlb_pkg::NUM_ENTRIES-1:0] match;
  logic                            lkp_hit;
  logic [tlb_pkg::ENTRY_IDX_W-1:0] lkp_idx;
  tlb_pkg::tlb_entry_t             sel_entry;
  logic [tlb_pkg::IN_PAGE_W-1:0]   page_delta;
  logic [tlb_pkg::OUT_PAGE_W-1:0]  out_page;
  logic [tlb_pkg::OUT_ADDR_W-1:0]  lkp_addr;

  logic                            res_valid_q;
  logic                            res_hit_q;
  logic [tlb_pkg::OUT_ADDR_W-1:0]  res_addr_q;
  payload_t                        res_payload_q;

  assign in_page = req_addr_i[tlb_pkg::IN_ADDR_W-1:tlb_pkg::PAGE_OFS_W];
  assign in_ofs  = req_addr_i[tlb_pkg::PAGE_OFS_W-1:0];

  // Range compare against every entry; writes skip read-only entries
  always_comb begin
    for (int i = 0; i < tlb_pkg::NUM_ENTRIES; i++) begin
      match[i] = entries_i[i].valid
              && (in_page >= entries_i[i].first_page)
              && (in_page <= entries_i[i].last_page)
              && !(is_write_i && entries_i[i].read_only);
    end
  end

  // Scan downwards so the lowest index is the last one kept
  always_comb begin
    lkp_hit = 1'b0;
    lkp_idx = '0;
    for (int i = tlb_pkg::NUM_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        lkp_hit = 1'b1;
        lkp_idx = tlb_pkg::ENTRY_IDX_W'(i);
      end
    end
  end

  // Output page is base plus distance from the first page
  assign sel_entry  = entries_i[lkp_idx];
  assign page_delta = in_page - sel_entry.first_page;
  assign out_page   = sel_entry.out_base
                    + {{(tlb_pkg::OUT_PAGE_W - tlb_pkg::IN_PAGE_W){1'b0}}, page_delta};
  assign lkp_addr   = lkp_hit ? {out_page, in_ofs} : '0;

  // Accept when the register is empty or drains this cycle
  assign req_ready_o = !res_valid_q || res_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      res_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      res_hit_q     <= lkp_hit;
      res_addr_q    <= lkp_addr;
      res_payload_q <= req_payload_i;
    end
  end

  assign res_valid_o   = res_valid_q;
  assign res_hit_o     = res_hit_q;
  assign res_addr_o    = res_addr_q;
  assign res_payload_o = res_payload_q;

endmodule

//--- tlb_entry_table.sv
// All entries are invalid after reset; a strobed entry is seen by lookups from the next cycle
module tlb_entry_table (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  // Configuration strobe
  input  logic                                            cfg_we_i,
  input  logic [tlb_pkg::ENTRY_IDX_W-1:0]                 cfg_idx_i,
  input  tlb_pkg::tlb_entry_t                             cfg_entry_i,
  // Whole table, shared by both lookups
  output tlb_pkg::tlb_entry_t [tlb_pkg::NUM_ENTRIES-1:0]  entries_o
);

  tlb_pkg::tlb_entry_t [tlb_pkg::NUM_ENTRIES-1:0] entries_q;
  logic [tlb_pkg::NUM_ENTRIES-1:0]                entry_we;

  // One-hot write enable per entry
  always_comb begin
    for (int i = 0; i < tlb_pkg::NUM_ENTRIES; i++) begin
      entry_we[i] = cfg_we_i && (cfg_idx_i == tlb_pkg::ENTRY_IDX_W'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      entries_q <= '0;
    end else begin
      for (int i = 0; i < tlb_pkg::NUM_ENTRIES; i++) begin
        if (entry_we[i]) begin
          entries_q[i] <= cfg_entry_i;
        end
      end
    end
  end

  assign entries_o = entries_q;

endmodule

//--- tlb_pkg.sv
// Fixed 4 KiB pages, 32-bit input and 36-bit output addresses; writes leave as INCR bursts
package tlb_pkg;

  // Address widths
  localparam int unsigned IN_ADDR_W  = 32;
  localparam int unsigned OUT_ADDR_W = 36;
  localparam int unsigned PAGE_OFS_W = 12;

  // Page numbers are what is left above the offset
  localparam int unsigned IN_PAGE_W  = IN_ADDR_W - PAGE_OFS_W;
  localparam int unsigned OUT_PAGE_W = OUT_ADDR_W - PAGE_OFS_W;

  // Translation table size
  localparam int unsigned NUM_ENTRIES = 4;
  localparam int unsigned ENTRY_IDX_W = $clog2(NUM_ENTRIES);

  // Transaction fields
  localparam int unsigned ID_W    = 4;
  localparam int unsigned LEN_W   = 8;
  localparam int unsigned BURST_W = 2;

  // The write payload has no burst field, so write hits report INCR
  localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;

  // One translation entry covering input pages first_page..last_page
  typedef struct packed {
    logic                  valid;
    logic                  read_only;
    logic [IN_PAGE_W-1:0]  first_page;
    logic [IN_PAGE_W-1:0]  last_page;
    logic [OUT_PAGE_W-1:0] out_base;
  } tlb_entry_t;

  // Write-address payload
  typedef struct packed {
    logic [ID_W-1:0]  id;
    logic [LEN_W-1:0] len;
  } wr_meta_t;

  // Read-address payload, wider than the write one
  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [LEN_W-1:0]   len;
    logic [BURST_W-1:0] burst;
  } rd_meta_t;

endpackage
